//--- aluBranch.sv
`timescale 1ns/1ps

module aluBranch (
  input logic [31:0] instr,
  input logic [31:0] pc,
  input logic [31:0] rs1Data,
  input logic [31:0] rs2Data,
  input corePkg::instType instKind,
  input corePkg::aluOp aluOp,
  input logic aluASel,
  input logic aluBSel,
  input logic brUnsigned,
  output logic [31:0] aluResult,
  output logic brEq,
  output logic brLt
);

  logic [31:0] imm;
  logic [31:0] opA;
  logic [31:0] opB;

  always_comb begin
    case (instKind)
      corePkg::typeI: imm = {{20{instr[31]}}, instr[31:20]}; // shamt sits in imm[4:0]
      corePkg::typeS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      corePkg::typeB: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      corePkg::typeU: imm = {instr[31:12], 12'd0};
      corePkg::typeJ: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = 32'd0; // R type has none
    endcase
  end

  assign opA = aluASel ? pc : rs1Data;
  assign opB = aluBSel ? imm : rs2Data;

  always_comb begin
    case (aluOp)
      corePkg::aluAdd: aluResult = opA + opB;
      corePkg::aluPassB: aluResult = opB;
      corePkg::aluAddClearLsb: aluResult = (opA + opB) & ~32'd1; // jalr target
      corePkg::aluSub: aluResult = opA - opB;
      corePkg::aluSltu: aluResult = {31'd0, opA < opB};
      corePkg::aluSlt: aluResult = {31'd0, $signed(opA) < $signed(opB)};
      corePkg::aluXor: aluResult = opA ^ opB;
      corePkg::aluSra: aluResult = $signed(opA) >>> opB[4:0]; // sign fills
      default: aluResult = 32'd0;
    endcase
  end

  // comparator always on rs1/rs2, not on the alu operands
  assign brEq = rs1Data == rs2Data;
  assign brLt = brUnsigned ? (rs1Data < rs2Data) : ($signed(rs1Data) < $signed(rs2Data));

endmodule

//--- corePkg.sv
package corePkg;

  localparam int memWords = 256; // ram depth in words
  localparam int memAddrBits = 8; // word address width
  localparam logic [31:0] resetPc = 32'h0000_0000; // first fetch address

  // immediate format of the current instruction
  typedef enum logic [2:0] {
    typeR = 3'd0, // no immediate
    typeI = 3'd1, // alu imm, loads, jalr
    typeS = 3'd2, // stores
    typeB = 3'd3, // branches
    typeU = 3'd4, // lui, auipc
    typeJ = 3'd5 // jal
  } instType;

  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluPassB = 4'd1, // lui
    aluAddClearLsb = 4'd2, // jalr target
    aluSub = 4'd3,
    aluSltu = 4'd4,
    aluSlt = 4'd5, // signed compare
    aluXor = 4'd6,
    aluSra = 4'd7 // arithmetic right shift
  } aluOp;

  // writeback source for rd
  typedef enum logic [1:0] {
    wbMem = 2'd0, // load data
    wbAlu = 2'd1,
    wbPcPlus4 = 2'd2 // link address
  } wbSel;

  typedef enum logic [2:0] {
    stIdle = 3'd0, // waiting for start
    stFetch = 3'd1, // fetch req raised
    stFetchWait = 3'd2, // ir loads from rdata
    stExecute = 3'd3,
    stMemory = 3'd4, // loads and stores only
    stWriteback = 3'd5, // retire strobe
    stHalt = 3'd6 // after ebreak
  } seqState;

endpackage

//--- coreTb.sv
`timescale 1ns/1ps

module coreTb;

  localparam int progWords = 46;
  localparam int haltWatch = 20; // cycles watched after ebreak

  localparam logic [31:0] progMem [progWords] = '{
    32'h00500093, // 00 addi x1, x0, 5
    32'hFFD00113, // 04 addi x2, x0, -3
    32'h002081B3, // 08 add x3, x1, x2
    32'h40208233, // 0c sub x4, x1, x2
    32'h0020C2B3, // 10 xor x5, x1, x2
    32'h0020B333, // 14 sltu x6, x1, x2
    32'h00113393, // 18 sltiu x7, x2, 1
    32'h40115413, // 1c srai x8, x2, 1
    32'h00708013, // 20 addi x0, x1, 7
    32'h000084B3, // 24 add x9, x1, x0
    32'h12345537, // 28 lui x10, 0x12345
    32'h00001597, // 2c auipc x11, 0x1
    32'h00208463, // 30 beq x1, x2, +8
    32'h00908463, // 34 beq x1, x9, +8
    32'h00100F93, // 38 skipped
    32'h00909463, // 3c bne x1, x9, +8
    32'h00209463, // 40 bne x1, x2, +8
    32'h00100F93, // 44 skipped
    32'h0020C463, // 48 blt x1, x2, +8
    32'h00114463, // 4c blt x2, x1, +8
    32'h00100F93, // 50 skipped
    32'h00115463, // 54 bge x2, x1, +8
    32'h0020D463, // 58 bge x1, x2, +8
    32'h00100F93, // 5c skipped
    32'h00116463, // 60 bltu x2, x1, +8
    32'h0020E463, // 64 bltu x1, x2, +8
    32'h00100F93, // 68 skipped
    32'h0020F463, // 6c bgeu x1, x2, +8
    32'h00117463, // 70 bgeu x2, x1, +8
    32'h00100F93, // 74 skipped
    32'h0080066F, // 78 jal x12, +8
    32'h00100F93, // 7c skipped
    32'h09100693, // 80 addi x13, x0, 0x91
    32'h00068767, // 84 jalr x14, 0(x13)
    32'h00100F93, // 88 skipped
    32'h00100F93, // 8c skipped
    32'h80F187B7, // 90 lui x15, 0x80f18
    32'hF0178793, // 94 addi x15, x15, -255
    32'h20000813, // 98 addi x16, x0, 0x200
    32'h00F82023, // 9c sw x15, 0(x16)
    32'h00082883, // a0 lw x17, 0(x16)
    32'h00080903, // a4 lb x18, 0(x16)
    32'h00180983, // a8 lb x19, 1(x16)
    32'h00280A03, // ac lb x20, 2(x16)
    32'h00380A83, // b0 lb x21, 3(x16)
    32'h00100073 // b4 ebreak
  };

  logic clock;
  logic reset;
  logic start;
  logic loadEn;
  logic [corePkg::memAddrBits-1:0] loadAddr;
  logic [31:0] loadData;
  logic retire;
  logic [31:0] retirePc;
  logic [4:0] retireRd;
  logic [31:0] retireData;
  logic halted;

  string rowName [$]; // expected retire trace
  logic [31:0] expPc [$];
  logic [4:0] expRd [$];
  logic [31:0] expData [$];
  int cycles;
  int cycleLimit;

  coreTop coreTop_inst (
    .clock, .reset, .start, .loadEn, .loadAddr, .loadData,
    .retire, .retirePc, .retireRd, .retireData, .halted
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock; // 20 ns period
  end

  task automatic addRow(input string name, input logic [31:0] pc, input logic [4:0] rd,
                        input logic [31:0] data);
    rowName.push_back(name);
    expPc.push_back(pc);
    expRd.push_back(rd);
    expData.push_back(data);
  endtask

  task automatic buildTrace();
    addRow("addi x1", 32'h00, 5'd1, 32'h00000005);
    addRow("addi x2 neg", 32'h04, 5'd2, 32'hFFFFFFFD);
    addRow("add", 32'h08, 5'd3, 32'h00000002);
    addRow("sub", 32'h0C, 5'd4, 32'h00000008);
    addRow("xor", 32'h10, 5'd5, 32'hFFFFFFF8);
    addRow("sltu", 32'h14, 5'd6, 32'h00000001);
    addRow("sltiu", 32'h18, 5'd7, 32'h00000000);
    addRow("srai neg", 32'h1C, 5'd8, 32'hFFFFFFFE);
    addRow("addi x0", 32'h20, 5'd0, 32'h00000000); // x0 write dropped
    addRow("add x0 readback", 32'h24, 5'd9, 32'h00000005);
    addRow("lui", 32'h28, 5'd10, 32'h12345000);
    addRow("auipc", 32'h2C, 5'd11, 32'h0000102C);
    addRow("beq not taken", 32'h30, 5'd0, 32'h0);
    addRow("beq taken", 32'h34, 5'd0, 32'h0);
    addRow("bne not taken", 32'h3C, 5'd0, 32'h0); // pc shows the skip
    addRow("bne taken", 32'h40, 5'd0, 32'h0);
    addRow("blt not taken", 32'h48, 5'd0, 32'h0);
    addRow("blt taken", 32'h4C, 5'd0, 32'h0);
    addRow("bge not taken", 32'h54, 5'd0, 32'h0);
    addRow("bge taken", 32'h58, 5'd0, 32'h0);
    addRow("bltu not taken", 32'h60, 5'd0, 32'h0);
    addRow("bltu taken", 32'h64, 5'd0, 32'h0);
    addRow("bgeu not taken", 32'h6C, 5'd0, 32'h0);
    addRow("bgeu taken", 32'h70, 5'd0, 32'h0);
    addRow("jal link", 32'h78, 5'd12, 32'h0000007C);
    addRow("addi odd target", 32'h80, 5'd13, 32'h00000091);
    addRow("jalr link", 32'h84, 5'd14, 32'h00000088); // lands on 0x90
    addRow("lui store word", 32'h90, 5'd15, 32'h80F18000);
    addRow("addi store word", 32'h94, 5'd15, 32'h80F17F01);
    addRow("addi base", 32'h98, 5'd16, 32'h00000200);
    addRow("sw", 32'h9C, 5'd0, 32'h0);
    addRow("lw", 32'hA0, 5'd17, 32'h80F17F01);
    addRow("lb lane 0", 32'hA4, 5'd18, 32'h00000001);
    addRow("lb lane 1", 32'hA8, 5'd19, 32'h0000007F);
    addRow("lb lane 2", 32'hAC, 5'd20, 32'hFFFFFFF1); // sign bit set
    addRow("lb lane 3", 32'hB0, 5'd21, 32'hFFFFFF80);
    addRow("ebreak", 32'hB4, 5'd0, 32'h0);
  endtask

  task automatic stopRun(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  task automatic checkField(input string name, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      stopRun($sformatf("mismatch %s %s: expected %h, actual %h",
                        name, field, expected, actual));
    end
  endtask

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      stopRun($sformatf("timeout: trace not finished after %0d cycles", cycles));
    end
  end

  initial begin
    int i;
    reset = 1'b1;
    start = 1'b0;
    loadEn = 1'b0;
    loadAddr = '0;
    loadData = 32'd0;
    cycles = 0;
    buildTrace();
    cycleLimit = 10 * expPc.size() + progWords + haltWatch + 10; // reset and start margin
    repeat (3) @(posedge clock);
    #2 reset = 1'b0;
    for (i = 0; i < progWords; i++) begin
      loadEn = 1'b1; // one word per cycle
      loadAddr = i[corePkg::memAddrBits-1:0];
      loadData = progMem[i];
      @(posedge clock);
      #2;
    end
    loadEn = 1'b0;
    start = 1'b1;
    @(posedge clock);
    #2 start = 1'b0;
    for (i = 0; i < expPc.size(); i++) begin
      @(negedge clock); // step past the previous strobe
      while (retire !== 1'b1) begin
        @(negedge clock);
      end
      checkField(rowName[i], "pc", expPc[i], retirePc);
      checkField(rowName[i], "rd", {27'd0, expRd[i]}, {27'd0, retireRd});
      checkField(rowName[i], "data", expData[i], retireData);
    end
    repeat (haltWatch) begin
      @(negedge clock);
      assert (halted === 1'b1 && retire === 1'b0) else begin
        stopRun("core did not stay halted after ebreak, or retired again");
      end
    end
    $display("sim passed");
    $finish;
  end

endmodule

//--- coreTop.sv
`timescale 1ns/1ps

module coreTop (
  input logic clock,
  input logic reset,
  input logic start,
  input logic loadEn,
  input logic [corePkg::memAddrBits-1:0] loadAddr,
  input logic [31:0] loadData,
  output logic retire,
  output logic [31:0] retirePc,
  output logic [4:0] retireRd,
  output logic [31:0] retireData,
  output logic halted
);

  memBus fetchBus ();
  memBus dataBus ();

  logic [31:0] instr;
  logic [31:0] pc;
  logic [31:0] rs1Data;
  logic [31:0] rs2Data;
  logic [31:0] aluResult;
  logic [31:0] lsuData; // load result from lsu
  logic [31:0] rdData;
  logic brEq;
  logic brLt;
  logic brUnsigned;
  logic regWrite;
  logic memRead;
  logic memWrite;
  logic isEbreak;
  logic pcSel;
  logic aluASel;
  logic aluBSel;
  logic memStart;
  logic memDone;
  logic regWriteEn;
  logic [3:0] readMask;
  logic [3:0] writeMask;
  corePkg::wbSel wbSel;
  corePkg::aluOp aluOp;
  corePkg::instType instKind;

  instDecoder instDecoder_inst (
    .opcode(instr[6:0]), .funct3(instr[14:12]), .funct7(instr[31:25]),
    .brEq, .brLt, .regWrite, .memRead, .memWrite, .isEbreak, .pcSel,
    .aluASel, .aluBSel, .wbSel, .aluOp, .brUnsigned, .readMask, .writeMask, .instKind
  );

  regFile regFile_inst (
    .clock, .reset, .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]),
    .rs1Data, .rs2Data, .writeEn(regWriteEn), .rdAddr(instr[11:7]), .rdData
  );

  aluBranch aluBranch_inst (
    .instr, .pc, .rs1Data, .rs2Data, .instKind, .aluOp,
    .aluASel, .aluBSel, .brUnsigned, .aluResult, .brEq, .brLt
  );

  instrSequencer instrSequencer_inst (
    .clock, .reset, .start, .fetchBus(fetchBus.requester), .instr, .pc,
    .regWrite, .memRead, .memWrite, .isEbreak, .pcSel, .wbSel,
    .aluResult, .loadData(lsuData), .memDone, .memStart, .regWriteEn, .rdData,
    .retire, .retirePc, .retireRd, .retireData, .halted
  );

  loadStoreUnit loadStoreUnit_inst (
    .clock, .reset, .memStart, .memRead, .memWrite, .readMask, .writeMask,
    .address(aluResult), .storeData(rs2Data), .dataBus(dataBus.requester),
    .loadData(lsuData), .memDone
  );

  memArbiter memArbiter_inst (
    .clock, .loadEn, .loadAddr, .loadData,
    .fetchBus(fetchBus.arbiter), .dataBus(dataBus.arbiter)
  );

endmodule

//--- coreTop_sva.sv
`timescale 1ns/1ps

module coreTopSva (
  input logic clock,
  input logic reset,
  input logic loadEn,
  input logic fetchReq,
  input logic fetchGnt,
  input logic dataReq,
  input logic dataGnt,
  input logic retire,
  input logic halted,
  input corePkg::seqState state
);

  // one ram access per cycle with loader writes counted
  singleGrant: assert property (@(posedge clock) disable iff (reset)
    !(fetchGnt && dataGnt) && !(loadEn && (fetchGnt || dataGnt)))
    else $error("more than one ram grant in a cycle");

  noRetireHalted: assert property (@(posedge clock) disable iff (reset)
    !(retire && halted))
    else $error("retire strobe while halted");

  fetchReqHeld: assert property (@(posedge clock) disable iff (reset)
    fetchReq && !fetchGnt |=> fetchReq) // waits out back-pressure
    else $error("fetch request dropped before grant");

  dataReqHeld: assert property (@(posedge clock) disable iff (reset)
    dataReq && !dataGnt |=> dataReq)
    else $error("load/store request dropped before grant");

  haltSticky: assert property (@(posedge clock) disable iff (reset)
    state == corePkg::stHalt |=> state == corePkg::stHalt)
    else $error("sequencer left halt");

endmodule

bind coreTop coreTopSva coreTopSva_inst (
  .clock,
  .reset,
  .loadEn,
  .fetchReq(fetchBus.req),
  .fetchGnt(fetchBus.gnt),
  .dataReq(dataBus.req),
  .dataGnt(dataBus.gnt),
  .retire,
  .halted,
  .state(instrSequencer_inst.state)
);

//--- flist.f
corePkg.sv
memBus.sv
instDecoder.sv
regFile.sv
aluBranch.sv
instrSequencer.sv
loadStoreUnit.sv
memArbiter.sv
coreTop.sv
coreTop_sva.sv
coreTb.sv

//--- instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
  input logic [6:0] opcode,
  input logic [2:0] funct3,
  input logic [6:0] funct7,
  input logic brEq, // rs1 == rs2
  input logic brLt, // rs1 < rs2, sign per brUnsigned
  output logic regWrite,
  output logic memRead,
  output logic memWrite,
  output logic isEbreak,
  output logic pcSel, // 1 takes aluResult as next pc
  output logic aluASel, // 1 selects pc
  output logic aluBSel, // 1 selects immediate
  output corePkg::wbSel wbSel,
  output corePkg::aluOp aluOp,
  output logic brUnsigned,
  output logic [3:0] readMask,
  output logic [3:0] writeMask,
  output corePkg::instType instKind
);

  // row layout {regWrite, memRead, memWrite, isEbreak, pcSel, aSel, bSel, wbSel, aluOp}
  logic [12:0] ctlOp; // keyed by opcode
  logic [12:0] ctlF3; // keyed by opcode + funct3
  logic [12:0] ctlF7; // keyed by opcode + funct3 + funct7
  logic [12:0] ctl;
  logic [8:0] maskF3; // {brUnsigned, readMask, writeMask}
  logic brTaken;

  always_comb begin
    case (opcode)
      7'b0010111: ctlOp = {7'b1000011, corePkg::wbAlu, corePkg::aluAdd}; // auipc
      7'b0110111: ctlOp = {7'b1000001, corePkg::wbAlu, corePkg::aluPassB}; // lui
      7'b1101111: ctlOp = {7'b1000111, corePkg::wbPcPlus4, corePkg::aluAdd}; // jal
      default: ctlOp = 13'd0;
    endcase
  end

  always_comb begin
    maskF3 = 9'd0;
    case ({opcode, funct3})
      10'b0010011_000: ctlF3 = {7'b1000001, corePkg::wbAlu, corePkg::aluAdd}; // addi
      10'b0010011_011: ctlF3 = {7'b1000001, corePkg::wbAlu, corePkg::aluSltu}; // sltiu
      10'b1110011_000: ctlF3 = {7'b0001000, 6'd0}; // ebreak
      10'b1100111_000: ctlF3 = {7'b1000101, corePkg::wbPcPlus4, corePkg::aluAddClearLsb}; // jalr
      10'b0100011_010: begin // sw
        ctlF3 = {7'b0010001, corePkg::wbMem, corePkg::aluAdd};
        maskF3 = {1'b0, 4'b0000, 4'b1111};
      end
      10'b0000011_010: begin // lw
        ctlF3 = {7'b1100001, corePkg::wbMem, corePkg::aluAdd};
        maskF3 = {1'b0, 4'b1111, 4'b0000};
      end
      10'b0000011_000: begin // lb
        ctlF3 = {7'b1100001, corePkg::wbMem, corePkg::aluAdd};
        maskF3 = {1'b0, 4'b0001, 4'b0000};
      end
      10'b1100011_000, 10'b1100011_001, 10'b1100011_100, 10'b1100011_101: begin
        ctlF3 = {7'b0000011, corePkg::wbMem, corePkg::aluAdd}; // signed branches to pc+imm
      end
      10'b1100011_110, 10'b1100011_111: begin // bltu, bgeu
        ctlF3 = {7'b0000011, corePkg::wbMem, corePkg::aluAdd};
        maskF3 = {1'b1, 4'b0000, 4'b0000};
      end
      default: ctlF3 = 13'd0;
    endcase
  end

  always_comb begin
    case ({opcode, funct3, funct7})
      17'b0110011_000_0000000: ctlF7 = {7'b1000000, corePkg::wbAlu, corePkg::aluAdd}; // add
      17'b0110011_000_0100000: ctlF7 = {7'b1000000, corePkg::wbAlu, corePkg::aluSub}; // sub
      17'b0110011_100_0000000: ctlF7 = {7'b1000000, corePkg::wbAlu, corePkg::aluXor}; // xor
      17'b0110011_011_0000000: ctlF7 = {7'b1000000, corePkg::wbAlu, corePkg::aluSltu}; // sltu
      17'b0010011_101_0100000: ctlF7 = {7'b1000001, corePkg::wbAlu, corePkg::aluSra}; // srai
      default: ctlF7 = 13'd0;
    endcase
  end

  always_comb begin
    case ({opcode, funct3})
      10'b1100011_000: brTaken = brEq; // beq
      10'b1100011_001: brTaken = ~brEq; // bne
      10'b1100011_100, 10'b1100011_110: brTaken = brLt; // blt, bltu
      10'b1100011_101, 10'b1100011_111: brTaken = ~brLt; // bge, bgeu
      default: brTaken = 1'b0;
    endcase
  end

  assign ctl = ctlOp | ctlF3 | ctlF7; // at most one level hits
  assign {regWrite, memRead, memWrite, isEbreak} = ctl[12:9];
  assign pcSel = ctl[8] | brTaken; // jumps or resolved branch
  assign {aluASel, aluBSel} = ctl[7:6];
  assign wbSel = corePkg::wbSel'(ctl[5:4]);
  assign aluOp = corePkg::aluOp'(ctl[3:0]);
  assign {brUnsigned, readMask, writeMask} = maskF3;

  always_comb begin
    case (opcode)
      7'b0110111, 7'b0010111: instKind = corePkg::typeU; // lui, auipc
      7'b1101111: instKind = corePkg::typeJ;
      7'b1100111, 7'b0000011, 7'b0010011, 7'b1110011: instKind = corePkg::typeI;
      7'b1100011: instKind = corePkg::typeB;
      7'b0100011: instKind = corePkg::typeS;
      default: instKind = corePkg::typeR; // also unknown
    endcase
  end

endmodule

//--- instrSequencer.sv
`timescale 1ns/1ps

module instrSequencer (
  input logic clock,
  input logic reset,
  input logic start,
  memBus.requester fetchBus,
  output logic [31:0] instr,
  output logic [31:0] pc,
  input logic regWrite,
  input logic memRead,
  input logic memWrite,
  input logic isEbreak,
  input logic pcSel,
  input corePkg::wbSel wbSel,
  input logic [31:0] aluResult,
  input logic [31:0] loadData,
  input logic memDone,
  output logic memStart,
  output logic regWriteEn,
  output logic [31:0] rdData,
  output logic retire,
  output logic [31:0] retirePc,
  output logic [4:0] retireRd,
  output logic [31:0] retireData,
  output logic halted
);

  corePkg::seqState state;
  corePkg::seqState nextState;
  logic [31:0] loadReg; // load result held for writeback
  logic [31:0] pcPlus4;
  logic wbValid; // rd really written

  always_comb begin
    nextState = state;
    case (state)
      corePkg::stIdle: if (start) nextState = corePkg::stFetch;
      corePkg::stFetch: if (fetchBus.gnt) nextState = corePkg::stFetchWait;
      corePkg::stFetchWait: nextState = corePkg::stExecute;
      corePkg::stExecute: begin
        if (memRead || memWrite) begin
          nextState = corePkg::stMemory;
        end else begin
          nextState = corePkg::stWriteback;
        end
      end
      corePkg::stMemory: if (memDone) nextState = corePkg::stWriteback;
      corePkg::stWriteback: begin
        if (isEbreak) begin
          nextState = corePkg::stHalt;
        end else begin
          nextState = corePkg::stFetch;
        end
      end
      default: nextState = state; // halt is sticky
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= corePkg::stIdle;
      pc <= corePkg::resetPc;
      instr <= 32'd0; // decodes as all-inactive
      memStart <= 1'b0;
    end else begin
      state <= nextState;
      memStart <= (state == corePkg::stExecute) && (memRead || memWrite); // first memory cycle
      if (state == corePkg::stFetchWait) begin
        instr <= fetchBus.rdata;
      end
      if (state == corePkg::stWriteback && !isEbreak) begin
        pc <= pcSel ? aluResult : pcPlus4;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (memDone) begin
      loadReg <= loadData;
    end
  end

  assign fetchBus.req = (state == corePkg::stFetch); // held until gnt
  assign fetchBus.we = 1'b0;
  assign fetchBus.addr = pc[corePkg::memAddrBits+1:2];
  assign fetchBus.wdata = 32'd0;
  assign fetchBus.wstrb = 4'd0;

  assign pcPlus4 = pc + 32'd4;

  always_comb begin
    case (wbSel)
      corePkg::wbMem: rdData = loadReg;
      corePkg::wbPcPlus4: rdData = pcPlus4; // link
      default: rdData = aluResult;
    endcase
  end

  assign regWriteEn = (state == corePkg::stWriteback) && regWrite;
  assign wbValid = regWrite && (instr[11:7] != 5'd0);
  assign retire = (state == corePkg::stWriteback);
  assign retirePc = pc;
  assign retireRd = wbValid ? instr[11:7] : 5'd0; // 0 for stores, branches, ebreak
  assign retireData = wbValid ? rdData : 32'd0;
  assign halted = (state == corePkg::stHalt);

endmodule

//--- loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit (
  input logic clock,
  input logic reset,
  input logic memStart,
  input logic memRead,
  input logic memWrite,
  input logic [3:0] readMask,
  input logic [3:0] writeMask,
  input logic [31:0] address, // byte address from alu
  input logic [31:0] storeData,
  memBus.requester dataBus,
  output logic [31:0] loadData,
  output logic memDone
);

  logic pending; // request lost arbitration
  logic [7:0] laneByte;

  // address and data come from a stable ir, so they hold until gnt
  assign dataBus.req = memStart || pending;
  assign dataBus.we = memWrite;
  assign dataBus.addr = address[corePkg::memAddrBits+1:2];
  assign dataBus.wdata = storeData;
  assign dataBus.wstrb = memWrite ? writeMask : 4'd0;

  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= 1'b0;
      memDone <= 1'b0;
    end else begin
      pending <= (memStart || pending) && !dataBus.gnt;
      memDone <= dataBus.gnt; // rdata lands with this
    end
  end

  assign laneByte = dataBus.rdata[{address[1:0], 3'b000} +: 8]; // lb lane

  always_comb begin
    if (!memRead) begin
      loadData = 32'd0; // stores return nothing
    end else if (readMask == 4'b1111) begin
      loadData = dataBus.rdata; // lw
    end else begin
      loadData = {{24{laneByte[7]}}, laneByte}; // lb sign extend
    end
  end

endmodule

//--- memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
  input logic clock,
  input logic loadEn,
  input logic [corePkg::memAddrBits-1:0] loadAddr,
  input logic [31:0] loadData,
  memBus.arbiter fetchBus,
  memBus.arbiter dataBus
);

  logic [31:0] ram [corePkg::memWords];
  logic [corePkg::memAddrBits-1:0] selAddr;
  logic selWe;
  logic [31:0] selWdata;
  logic [3:0] selWstrb;

  // loader always wins, then load/store, then fetch
  assign dataBus.gnt = dataBus.req && !loadEn;
  assign fetchBus.gnt = fetchBus.req && !loadEn && !dataBus.req;

  assign selAddr = dataBus.gnt ? dataBus.addr : fetchBus.addr;
  assign selWe = dataBus.gnt ? dataBus.we : (fetchBus.gnt && fetchBus.we);
  assign selWdata = dataBus.gnt ? dataBus.wdata : fetchBus.wdata;
  assign selWstrb = dataBus.gnt ? dataBus.wstrb : fetchBus.wstrb;

  always_ff @(posedge clock) begin
    if (loadEn) begin
      ram[loadAddr] <= loadData; // program load, single cycle
    end else if (selWe) begin
      for (int i = 0; i < 4; i++) begin
        if (selWstrb[i]) begin
          ram[selAddr][8*i +: 8] <= selWdata[8*i +: 8];
        end
      end
    end
    if (dataBus.gnt) begin
      dataBus.rdata <= ram[selAddr]; // old word on a write
    end
    if (fetchBus.gnt) begin
      fetchBus.rdata <= ram[selAddr];
    end
  end

endmodule

//--- memBus.sv
`timescale 1ns/1ps

interface memBus;
  logic req; // level, held until gnt
  logic we;
  logic [corePkg::memAddrBits-1:0] addr; // word address
  logic [31:0] wdata;
  logic [3:0] wstrb; // byte lanes for writes
  logic gnt; // one cycle accept strobe
  logic [31:0] rdata; // valid the cycle after gnt

  // one ram port as seen from the requester
  modport requester (output req, we, addr, wdata, wstrb, input gnt, rdata);

  modport arbiter (input req, we, addr, wdata, wstrb, output gnt, rdata);
endinterface

//--- regFile.sv
`timescale 1ns/1ps

module regFile (
  input logic clock,
  input logic reset,
  input logic [4:0] rs1Addr,
  input logic [4:0] rs2Addr,
  output logic [31:0] rs1Data,
  output logic [31:0] rs2Data,
  input logic writeEn,
  input logic [4:0] rdAddr,
  input logic [31:0] rdData
);

  logic [31:0] regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (writeEn && rdAddr != 5'd0) begin // x0 never written
      regs[rdAddr] <= rdData;
    end
  end

  assign rs1Data = (rs1Addr == 5'd0) ? 32'd0 : regs[rs1Addr]; // async read
  assign rs2Data = (rs2Addr == 5'd0) ? 32'd0 : regs[rs2Addr];

endmodule

//--- run.sh
#!/bin/sh
# build and run the core testbench with verilator

verilator --binary --timing --assert --top-module coreTb -f flist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/VcoreTb > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
if [ $runStatus -ne 0 ]; then
  echo "simulation exited with status $runStatus"
  exit 1
fi
exit 0
